// ==== tests/cache_testdata.txt ====
# name op address wdata wmask expected_rdata line_reads line_writes (all hex except counts)
# Memory words start as byte address times 0x0101, set index is address bits 6:4
rd_cold            r 0020 0000 0 2020 1 0
rd_repeat          r 0020 0000 0 2020 0 0
rd_offset          r 002a 0000 0 2a2a 0 0
wr_low_byte        w 0024 00ab 1 0000 0 0
rd_low_merge       r 0024 0000 0 24ab 0 0
wr_high_byte       w 0026 cd00 2 0000 0 0
rd_high_merge      r 0026 0000 0 cd26 0 0
wr_word            w 0028 beef 3 0000 0 0
rd_word            r 0028 0000 0 beef 0 0
rd_second_tag      r 00a0 0000 0 a0a0 1 0
rd_first_tag       r 0020 0000 0 2020 0 0
rd_second_again    r 00a2 0000 0 a2a2 0 0
rd_dirty_evict     r 0120 0000 0 2120 1 1
rd_survivor        r 00a4 0000 0 a4a4 0 0
rd_written_back    r 0024 0000 0 24ab 1 0
rd_back_high       r 0026 0000 0 cd26 0 0
rd_back_word       r 0028 0000 0 beef 0 0
rd_clean_evict     r 01a0 0000 0 a1a0 1 0
wr_alloc           w 0302 1234 3 0000 1 0
rd_alloc           r 0300 0000 0 0300 0 0
rd_set0_second     r 0382 0000 0 8582 1 0
rd_set0_dirty      r 0402 0000 0 0602 1 1
rd_alloc_back      r 0302 0000 0 1234 1 0

// ==== src.f ====
src/lc3b_pkg.sv
src/cache_pkg.sv
src/cache_array.sv
src/cache_datapath.sv
src/cache_control.sv
src/cache_top.sv
tests/cache_properties.sv
tests/cache_tb.sv

// ==== tests/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

  // --------------------------------------------------------------------------
  // Test vectors and DUT signals
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic                    write;
    lc3b_pkg::lc3b_mem_wmask wmask;
    lc3b_pkg::lc3b_word      address;
    lc3b_pkg::lc3b_word      wdata;
    lc3b_pkg::lc3b_word      exp_rdata;
    logic [15:0]             exp_reads;
    logic [15:0]             exp_writes;
  } test_vec_t;

  localparam int clk_period = 20;

  logic                   clk;
  logic                   rst_n;
  lc3b_pkg::cpu_req_t     cpu_req;
  lc3b_pkg::lc3b_word     mem_rdata;
  logic                   mem_resp;
  cache_pkg::pmem_req_t   pmem_req;
  cache_pkg::cache_line_t pmem_rdata;
  logic                   pmem_resp;

  test_vec_t tests[$];
  string     test_names[$];
  logic      tests_loaded;
  int        line_reads;
  int        line_writes;
  integer    seed;

  cache_pkg::cache_line_t mem_lines [4096];     // Indexed by address bits 15:4
  logic                   mem_written [4096];

  cache_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_req   (cpu_req),
    .mem_rdata (mem_rdata),
    .mem_resp  (mem_resp),
    .pmem_req  (pmem_req),
    .pmem_rdata(pmem_rdata),
    .pmem_resp (pmem_resp)
  );

  always #(clk_period / 2) clk = ~clk;

  // Untouched lines hold each word's byte address times 0x0101
  function automatic cache_pkg::cache_line_t read_line(input lc3b_pkg::lc3b_word line_addr);
    cache_pkg::cache_line_t line;
    lc3b_pkg::lc3b_word     word_addr;
    if (mem_written[line_addr[15:4]]) begin
      return mem_lines[line_addr[15:4]];
    end
    for (int w = 0; w < 8; w++) begin
      word_addr = {line_addr[15:4], 4'h0} + lc3b_pkg::lc3b_word'(2 * w);
      line[w * 16 +: 16] = word_addr * 16'h0101;
    end
    return line;
  endfunction

  task automatic check(input string name, input logic [15:0] expected,
                       input logic [15:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          code;
    string       name;
    string       op;
    string       rest;
    logic [15:0] fields [5];
    int          exp_reads;
    int          exp_writes;
    test_vec_t   vec;
    fd = $fopen("tests/cache_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file tests/cache_testdata.txt");
      $display("sim failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", name);
      if (code != 1) begin
        break;                                  // Trailing blank lines
      end
      if (name[0] == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%s %h %h %h %h %d %d", op, fields[0], fields[1], fields[2],
                       fields[3], exp_reads, exp_writes);
        if (code != 7) begin
          $display("Malformed test data line for test %s", name);
          $display("sim failed");
          $fatal(1);
        end
        vec.write      = (op == "w");
        vec.address    = fields[0];
        vec.wdata      = fields[1];
        vec.wmask      = fields[2][1:0];
        vec.exp_rdata  = fields[3];
        vec.exp_reads  = 16'(exp_reads);
        vec.exp_writes = 16'(exp_writes);
        tests.push_back(vec);
        test_names.push_back(name);
      end
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------------------------------
  // One CPU access, held until mem_resp
  // --------------------------------------------------------------------------
  task automatic run_access(input test_vec_t vec, input string name);
    @(posedge clk);
    line_reads  = 0;
    line_writes = 0;
    cpu_req <= '{read: !vec.write, write: vec.write, wmask: vec.wmask,
                 address: vec.address, wdata: vec.wdata};
    @(negedge clk);
    while (!mem_resp) begin
      @(negedge clk);
    end
    if (!vec.write) begin
      check(name, vec.exp_rdata, mem_rdata);
    end
    check({name, " line reads"}, vec.exp_reads, 16'(line_reads));
    check({name, " line writes"}, vec.exp_writes, 16'(line_writes));
    @(posedge clk);
    cpu_req <= '0;
  endtask

  // --------------------------------------------------------------------------
  // Memory model with random latency
  // --------------------------------------------------------------------------
  initial begin : memory_model
    lc3b_pkg::lc3b_word     addr;
    cache_pkg::cache_line_t wdata;
    logic                   is_write;
    int                     latency;
    seed       = 90;
    pmem_resp  = 1'b0;
    pmem_rdata = '0;
    foreach (mem_written[i]) begin
      mem_written[i] = 1'b0;
    end
    forever begin
      @(negedge clk);
      if (rst_n && (pmem_req.read || pmem_req.write)) begin
        addr     = pmem_req.address;
        is_write = pmem_req.write;
        wdata    = pmem_req.wdata;
        latency  = 1 + ($unsigned($random(seed)) % 6);   // 1 to 6 cycles
        repeat (latency) @(posedge clk);
        if (is_write) begin
          mem_lines[addr[15:4]]   = wdata;
          mem_written[addr[15:4]] = 1'b1;
          line_writes++;
        end else begin
          pmem_rdata <= read_line(addr);
          line_reads++;
        end
        pmem_resp <= 1'b1;
        @(posedge clk);
        pmem_resp <= 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (uut.props.failures != 0) begin
      $display("An assertion bound to the DUT failed");
      $display("sim failed");
      $fatal(1);
    end
  end

  initial begin : watchdog
    int limit_ns;
    wait (tests_loaded === 1'b1);
    limit_ns = (tests.size() * 20 + 100) * clk_period;
    #(limit_ns);
    $display("Timeout: the tests did not finish within %0d ns", limit_ns);
    $display("sim failed");
    $fatal(1);
  end

  initial begin : stimulus
    clk          = 1'b0;
    rst_n        = 1'b0;
    cpu_req      = '0;
    tests_loaded = 1'b0;
    line_reads   = 0;
    line_writes  = 0;
    load_tests();
    tests_loaded = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    foreach (tests[i]) begin
      run_access(tests[i], test_names[i]);
    end
    repeat (2) @(posedge clk);
    if (tests.size() > 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("No tests were found in the test data file");
      $display("sim failed");
      $fatal(1);
    end
  end

endmodule : cache_tb

// ==== tests/cache_properties.sv ====
`timescale 1ns/1ps

module cache_properties (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 mem_resp,
  input cache_pkg::pmem_req_t pmem_req,
  input logic                 pmem_resp
);

  int failures = 0;   // Read by the testbench

  // --------------------------------------------------------------------------
  // CPU side
  // --------------------------------------------------------------------------
  mem_resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    mem_resp |=> !mem_resp)
    else begin
      failures++;
      $error("mem_resp stayed high for more than one cycle");
    end

  // --------------------------------------------------------------------------
  // Memory side
  // --------------------------------------------------------------------------
  pmem_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(pmem_req.read && pmem_req.write))
    else begin
      failures++;
      $error("pmem read and write strobes high together");
    end

  pmem_read_held: assert property (@(posedge clk) disable iff (!rst_n)
    (pmem_req.read && !pmem_resp) |=> pmem_req.read)
    else begin
      failures++;
      $error("pmem read dropped before pmem_resp");
    end

  pmem_write_held: assert property (@(posedge clk) disable iff (!rst_n)
    (pmem_req.write && !pmem_resp) |=> pmem_req.write)
    else begin
      failures++;
      $error("pmem write dropped before pmem_resp");
    end

  quiet_in_reset: assert property (@(posedge clk)
    !rst_n |-> (!pmem_req.read && !pmem_req.write && !mem_resp))
    else begin
      failures++;
      $error("strobe active during reset");
    end

endmodule : cache_properties

bind cache_top cache_properties props (
  .clk      (clk),
  .rst_n    (rst_n),
  .mem_resp (mem_resp),
  .pmem_req (pmem_req),
  .pmem_resp(pmem_resp)
);

// ==== src/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  lc3b_pkg::cpu_req_t     cpu_req,
  output lc3b_pkg::lc3b_word     mem_rdata,
  output logic                   mem_resp,
  output cache_pkg::pmem_req_t   pmem_req,
  input  cache_pkg::cache_line_t pmem_rdata,
  input  logic                   pmem_resp
);

  logic hit;
  logic victim_dirty;
  logic hit_update;
  logic fill_load;
  logic sel_victim_addr;
  logic pmem_read;
  logic pmem_write;

  lc3b_pkg::lc3b_word     pmem_address;
  cache_pkg::cache_line_t pmem_wdata;

  cache_datapath datapath (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_req        (cpu_req),
    .pmem_rdata     (pmem_rdata),
    .hit_update     (hit_update),
    .fill_load      (fill_load),
    .sel_victim_addr(sel_victim_addr),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .mem_rdata      (mem_rdata),
    .pmem_address   (pmem_address),
    .pmem_wdata     (pmem_wdata)
  );

  cache_control control (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_read       (cpu_req.read),
    .cpu_write      (cpu_req.write),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .pmem_resp      (pmem_resp),
    .mem_resp       (mem_resp),
    .hit_update     (hit_update),
    .fill_load      (fill_load),
    .sel_victim_addr(sel_victim_addr),
    .pmem_read      (pmem_read),
    .pmem_write     (pmem_write)
  );

  // Memory side request
  assign pmem_req = '{read: pmem_read, write: pmem_write,
                      address: pmem_address, wdata: pmem_wdata};

endmodule : cache_top

// ==== src/cache_control.sv ====
`timescale 1ns/1ps

module cache_control (
  input  logic clk,
  input  logic rst_n,
  input  logic cpu_read,
  input  logic cpu_write,
  input  logic hit,
  input  logic victim_dirty,
  input  logic pmem_resp,
  output logic mem_resp,
  output logic hit_update,
  output logic fill_load,
  output logic sel_victim_addr,
  output logic pmem_read,
  output logic pmem_write
);

  cache_pkg::cache_state_t state;
  cache_pkg::cache_state_t next_state;
  logic                    request;

  assign request = cpu_read | cpu_write;

  // --------------------------------------------------------------------------
  // State register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= cache_pkg::idle_check;
    end else begin
      state <= next_state;
    end
  end

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------
  always_comb begin
    next_state = state;
    unique case (state)
      cache_pkg::idle_check: begin
        if (request && !hit) begin
          if (victim_dirty) begin
            next_state = cache_pkg::write_back;   // Line out before line in
          end else begin
            next_state = cache_pkg::fill;
          end
        end
      end

      cache_pkg::write_back: begin
        if (pmem_resp) begin
          next_state = cache_pkg::fill;
        end
      end

      cache_pkg::fill: begin
        if (pmem_resp) begin
          next_state = cache_pkg::idle_check;   // Retry now hits
        end
      end

      default: begin
        next_state = cache_pkg::idle_check;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------
  always_comb begin
    mem_resp        = 1'b0;
    hit_update      = 1'b0;
    fill_load       = 1'b0;
    sel_victim_addr = 1'b0;
    pmem_read       = 1'b0;
    pmem_write      = 1'b0;

    unique case (state)
      cache_pkg::idle_check: begin
        if (request && hit) begin
          mem_resp   = 1'b1;   // Zero wait cycles
          hit_update = 1'b1;   // LRU, data and dirty commit at the edge
        end
      end

      cache_pkg::write_back: begin
        pmem_write      = 1'b1;
        sel_victim_addr = 1'b1;
      end

      cache_pkg::fill: begin
        pmem_read = 1'b1;
        fill_load = pmem_resp;   // Line taken on the response cycle
      end

      default: begin
        mem_resp = 1'b0;
      end
    endcase
  end

endmodule : cache_control

// ==== src/cache_datapath.sv ====
`timescale 1ns/1ps

module cache_datapath (
  input  logic                    clk,
  input  logic                    rst_n,
  input  lc3b_pkg::cpu_req_t      cpu_req,
  input  cache_pkg::cache_line_t  pmem_rdata,
  input  logic                    hit_update,
  input  logic                    fill_load,
  input  logic                    sel_victim_addr,
  output logic                    hit,
  output logic                    victim_dirty,
  output lc3b_pkg::lc3b_word      mem_rdata,
  output lc3b_pkg::lc3b_word      pmem_address,
  output cache_pkg::cache_line_t  pmem_wdata
);

  cache_pkg::cache_tag_t    tag;
  cache_pkg::cache_index_t  index;
  cache_pkg::cache_offset_t offset;
  logic [cache_pkg::offset_bits-2:0] word_sel;

  logic [cache_pkg::tag_bits:0] vtag0_out;
  logic [cache_pkg::tag_bits:0] vtag1_out;
  logic [cache_pkg::tag_bits:0] vtag_in;
  logic                         valid0;
  logic                         valid1;
  cache_pkg::cache_tag_t        tag0;
  cache_pkg::cache_tag_t        tag1;
  logic                         hit0;
  logic                         hit1;

  cache_pkg::cache_line_t line0_out;
  cache_pkg::cache_line_t line1_out;
  cache_pkg::cache_line_t line_in;
  cache_pkg::cache_line_t hit_line;
  cache_pkg::cache_line_t merged_line;
  lc3b_pkg::lc3b_word     hit_word;
  lc3b_pkg::lc3b_word     merged_word;
  lc3b_pkg::lc3b_byte     low_byte;
  lc3b_pkg::lc3b_byte     high_byte;

  logic dirty0_out;
  logic dirty1_out;
  logic dirty_in;
  logic lru_out;
  logic lru_in;
  logic victim_way;
  logic victim_valid;
  cache_pkg::cache_tag_t victim_tag;

  logic write_hit;
  logic data0_write;
  logic data1_write;
  logic vtag0_write;
  logic vtag1_write;

  // --------------------------------------------------------------------------
  // Address split and tag compare
  // --------------------------------------------------------------------------
  assign offset   = cpu_req.address[cache_pkg::offset_bits-1:0];
  assign index    = cpu_req.address[cache_pkg::offset_bits +: cache_pkg::index_bits];
  assign tag      = cpu_req.address[cache_pkg::offset_bits + cache_pkg::index_bits +:
                                    cache_pkg::tag_bits];
  assign word_sel = offset[cache_pkg::offset_bits-1:1];   // Byte 0 of offset ignored

  assign {valid0, tag0} = vtag0_out;
  assign {valid1, tag1} = vtag1_out;
  assign hit0 = valid0 && (tag0 == tag);
  assign hit1 = valid1 && (tag1 == tag);
  assign hit  = hit0 | hit1;

  // --------------------------------------------------------------------------
  // Read word select and write merge
  // --------------------------------------------------------------------------
  assign hit_line  = hit1 ? line1_out : line0_out;
  assign hit_word  = hit_line[word_sel * lc3b_pkg::word_bits +: lc3b_pkg::word_bits];
  assign mem_rdata = hit_word;

  always_comb begin
    low_byte  = cpu_req.wmask[0] ? cpu_req.wdata[7:0]  : hit_word[7:0];
    high_byte = cpu_req.wmask[1] ? cpu_req.wdata[15:8] : hit_word[15:8];
    merged_word = {high_byte, low_byte};
    merged_line = hit_line;
    merged_line[word_sel * lc3b_pkg::word_bits +: lc3b_pkg::word_bits] = merged_word;
  end

  // --------------------------------------------------------------------------
  // Victim choice
  // --------------------------------------------------------------------------
  assign victim_way   = lru_out;                  // LRU names the way to evict
  assign victim_valid = victim_way ? valid1 : valid0;
  assign victim_tag   = victim_way ? tag1 : tag0;
  assign victim_dirty = victim_valid & (victim_way ? dirty1_out : dirty0_out);
  assign pmem_wdata   = victim_way ? line1_out : line0_out;

  assign pmem_address = sel_victim_addr ?
                        {victim_tag, index, {cache_pkg::offset_bits{1'b0}}} :
                        {tag, index, {cache_pkg::offset_bits{1'b0}}};

  // --------------------------------------------------------------------------
  // Array write strobes
  // --------------------------------------------------------------------------
  assign write_hit   = hit_update & cpu_req.write;
  assign data0_write = (write_hit & hit0) | (fill_load & ~victim_way);
  assign data1_write = (write_hit & hit1) | (fill_load & victim_way);
  assign vtag0_write = fill_load & ~victim_way;
  assign vtag1_write = fill_load & victim_way;

  assign line_in  = fill_load ? pmem_rdata : merged_line;
  assign vtag_in  = {1'b1, tag};
  assign dirty_in = ~fill_load;                   // Fill is clean, write hit is dirty
  assign lru_in   = hit0;                         // Other way becomes LRU

  cache_array #(.width(cache_pkg::tag_bits + 1)) vtag0 (
    .clk(clk), .rst_n(rst_n), .write(vtag0_write), .index(index),
    .datain(vtag_in), .dataout(vtag0_out)
  );

  cache_array #(.width(cache_pkg::tag_bits + 1)) vtag1 (
    .clk(clk), .rst_n(rst_n), .write(vtag1_write), .index(index),
    .datain(vtag_in), .dataout(vtag1_out)
  );

  cache_array #(.width(1)) dirty0 (
    .clk(clk), .rst_n(rst_n), .write(data0_write), .index(index),
    .datain(dirty_in), .dataout(dirty0_out)
  );

  cache_array #(.width(1)) dirty1 (
    .clk(clk), .rst_n(rst_n), .write(data1_write), .index(index),
    .datain(dirty_in), .dataout(dirty1_out)
  );

  cache_array #(.width(cache_pkg::line_bits)) data0 (
    .clk(clk), .rst_n(rst_n), .write(data0_write), .index(index),
    .datain(line_in), .dataout(line0_out)
  );

  cache_array #(.width(cache_pkg::line_bits)) data1 (
    .clk(clk), .rst_n(rst_n), .write(data1_write), .index(index),
    .datain(line_in), .dataout(line1_out)
  );

  cache_array #(.width(1)) lru (
    .clk(clk), .rst_n(rst_n), .write(hit_update), .index(index),
    .datain(lru_in), .dataout(lru_out)
  );

endmodule : cache_datapath

// ==== src/cache_array.sv ====
`timescale 1ns/1ps

module cache_array #(
  parameter int width = 1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   write,
  input  cache_pkg::cache_index_t index,
  input  logic [width-1:0]       datain,
  output logic [width-1:0]       dataout
);

  logic [width-1:0] entries [cache_pkg::num_sets];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < cache_pkg::num_sets; i++) begin
        entries[i] <= '0;
      end
    end else if (write) begin
      entries[index] <= datain;
    end
  end

  assign dataout = entries[index];   // Asynchronous read

endmodule : cache_array

// ==== src/cache_pkg.sv ====
package cache_pkg;

  // --------------------------------------------------------------------------
  // Geometry
  // --------------------------------------------------------------------------
  localparam int line_bits   = 128;
  localparam int offset_bits = 4;                      // 16-byte lines
  localparam int index_bits  = 3;
  localparam int tag_bits    = 9;
  localparam int num_sets    = 1 << index_bits;        // 8 sets

  typedef logic [line_bits-1:0]   cache_line_t;
  typedef logic [tag_bits-1:0]    cache_tag_t;
  typedef logic [index_bits-1:0]  cache_index_t;
  typedef logic [offset_bits-1:0] cache_offset_t;

  // --------------------------------------------------------------------------
  // Physical memory request
  // --------------------------------------------------------------------------
  // Address is line aligned, low offset bits are zero
  typedef struct packed {
    logic              read;
    logic              write;
    lc3b_pkg::lc3b_word address;
    cache_line_t       wdata;
  } pmem_req_t;

  // --------------------------------------------------------------------------
  // Controller states
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    idle_check = 2'b00,   // Tag check, hit service
    write_back = 2'b01,   // Dirty victim out to memory
    fill       = 2'b10    // New line in from memory
  } cache_state_t;

endpackage : cache_pkg

// ==== src/lc3b_pkg.sv ====
package lc3b_pkg;

  // --------------------------------------------------------------------------
  // Processor-side widths
  // --------------------------------------------------------------------------
  localparam int word_bits  = 16;
  localparam int byte_bits  = 8;
  localparam int wmask_bits = word_bits / byte_bits;

  typedef logic [word_bits-1:0]  lc3b_word;       // Data or byte address
  typedef logic [byte_bits-1:0]  lc3b_byte;
  typedef logic [wmask_bits-1:0] lc3b_mem_wmask;  // Bit 0 selects the low byte

  // --------------------------------------------------------------------------
  // CPU request toward the cache
  // --------------------------------------------------------------------------
  // Held steady by the CPU until the cycle mem_resp is high
  typedef struct packed {
    logic          read;
    logic          write;
    lc3b_mem_wmask wmask;
    lc3b_word      address;
    lc3b_word      wdata;
  } cpu_req_t;

endpackage : lc3b_pkg
